// ==== logic/rv_wb_pkg.sv ====
/*
 * Shared types and constants for the RV32I writeback end.
 * Holds the word, order and register index types, the writeback source
 * select codes, the load word union used for sub-word extraction, and
 * the reset PC and empty order markers. Every design file refers to
 * these through scoped names.
 */
`default_nettype none

package rv_wb_pkg;

    // one data or address word
    typedef logic [31:0] rv_word;

    // retirement order number, as on the formal retirement port
    typedef logic [63:0] rv_order;

    typedef logic [4:0] rv_reg_idx;  // x0..x31

    // writeback source select, encoding shared with the decode stage
    typedef enum logic [3:0] {
        alu_out  = 4'b0000,
        br_en    = 4'b0001,
        u_imm    = 4'b0010,
        lw       = 4'b0011,
        pc_plus4 = 4'b0100,
        lb       = 4'b0101,
        lbu      = 4'b0110,  // byte, zero extended
        lh       = 4'b0111,
        lhu      = 4'b1000   // halfword, zero extended
    } wb_sel_e;

    // one memory read word, seen either as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;   // bytes[0] is the lowest address
        logic [1:0][15:0] halves;  // halves[0] is the lower halfword
    } load_word_u;

    // boot address, also reported as pc while nothing retires
    localparam rv_word reset_pc = 32'h4000_0000;

    // no instruction has committed yet
    localparam rv_order order_none = 64'hffff_ffff_ffff_ffff;

endpackage : rv_wb_pkg

`default_nettype wire

// ==== logic/wb_if.sv ====
/*
 * One registered instruction on its way from the mem/wb pipeline
 * register to the writeback stage. The register drives it through the
 * producer modport and the writeback stage reads it as consumer.
 */
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

    logic                 valid;
    rv_wb_pkg::rv_order   order;
    rv_wb_pkg::rv_word    pc;
    rv_wb_pkg::wb_sel_e   sel;
    rv_wb_pkg::rv_reg_idx rd;
    logic                 ld_reg;     // instruction writes rd
    logic                 store;
    rv_wb_pkg::rv_word    alu_out;
    logic                 br_en;      // compare result
    rv_wb_pkg::rv_word    u_imm;
    rv_wb_pkg::rv_word    mem_rdata;  // raw word from data memory
    logic [1:0]           byte_off;   // low address bits of the load

    modport producer (
        output valid, order, pc, sel, rd, ld_reg, store,
        output alu_out, br_en, u_imm, mem_rdata, byte_off
    );

    modport consumer (
        input valid, order, pc, sel, rd, ld_reg, store,
        input alu_out, br_en, u_imm, mem_rdata, byte_off
    );

endinterface : wb_if

`default_nettype wire

// ==== logic/mem_wb_reg.sv ====
/*
 * mem/wb pipeline register.
 * Captures the results of one instruction from the memory stage when
 * in_valid is high at a rising edge. With in_valid low the valid bit
 * drops and the captured fields are held. One cycle of latency, one
 * instruction deep.
 */
`timescale 1ns/10ps
`default_nettype none

module mem_wb_reg (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire rv_wb_pkg::rv_order   in_order,
    input  wire rv_wb_pkg::rv_word    in_pc,
    input  wire rv_wb_pkg::wb_sel_e   in_sel,
    input  wire rv_wb_pkg::rv_reg_idx in_rd,
    input  wire logic                 in_ld_reg,
    input  wire logic                 in_store,
    input  wire rv_wb_pkg::rv_word    alu_out,
    input  wire logic                 br_en,
    input  wire rv_wb_pkg::rv_word    u_imm,
    input  wire rv_wb_pkg::rv_word    mem_rdata,
    input  wire logic [1:0]           mem_byte_off,
    wb_if.producer                    wb
);

    // valid is the only control bit here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= in_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb.order     <= in_order;
            wb.pc        <= in_pc;
            wb.sel       <= in_sel;
            wb.rd        <= in_rd;
            wb.ld_reg    <= in_ld_reg;
            wb.store     <= in_store;
            wb.alu_out   <= alu_out;
            wb.br_en     <= br_en;
            wb.u_imm     <= u_imm;
            wb.mem_rdata <= mem_rdata;
            wb.byte_off  <= mem_byte_off;
        end
    end

endmodule : mem_wb_reg

`default_nettype wire

// ==== logic/wb_stage.sv ====
/*
 * Writeback stage.
 * Selects the value returned to the register file, extends sub-word
 * loads, zeroes stores and decides whether the instruction commits.
 * An instruction whose order matches the last committed one is a held
 * repeat and is ignored. Commit fields follow the formal retirement
 * port and read as idle values between commits.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    wb_if.consumer                    wb,
    output      logic                 we,
    output      rv_wb_pkg::rv_reg_idx waddr,
    output      rv_wb_pkg::rv_word    wdata,
    output      logic                 commit_valid,
    output      rv_wb_pkg::rv_order   commit_order,
    output      rv_wb_pkg::rv_reg_idx commit_rd,
    output      rv_wb_pkg::rv_word    commit_wdata,
    output      rv_wb_pkg::rv_word    commit_pc
);

    rv_wb_pkg::load_word_u ld_word;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    rv_wb_pkg::rv_word     sel_data;
    rv_wb_pkg::rv_word     result;
    rv_wb_pkg::rv_order    last_order;
    logic                  commit;

    // pick the addressed byte and halfword out of the read word
    always_comb begin
        ld_word = rv_wb_pkg::load_word_u'(wb.mem_rdata);
        ld_byte = ld_word.bytes[wb.byte_off];
        ld_half = ld_word.halves[wb.byte_off[1]];  // halfword loads are aligned
    end

    always_comb begin
        case (wb.sel)
            rv_wb_pkg::alu_out:  sel_data = wb.alu_out;
            rv_wb_pkg::br_en:    sel_data = {31'b0, wb.br_en};
            rv_wb_pkg::u_imm:    sel_data = wb.u_imm;
            rv_wb_pkg::lw:       sel_data = wb.mem_rdata;
            rv_wb_pkg::pc_plus4: sel_data = wb.pc + 32'd4;
            rv_wb_pkg::lb:       sel_data = {{24{ld_byte[7]}}, ld_byte};
            rv_wb_pkg::lbu:      sel_data = {24'b0, ld_byte};
            rv_wb_pkg::lh:       sel_data = {{16{ld_half[15]}}, ld_half};
            rv_wb_pkg::lhu:      sel_data = {16'b0, ld_half};
            default:             sel_data = '0;  // unused codes
        endcase
    end

    // stores return nothing to the register file
    assign result = wb.store ? '0 : sel_data;

    // held stage shows the same order again, so only a new order commits
    assign commit = wb.valid && (wb.order != last_order);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_order <= rv_wb_pkg::order_none;
        end else if (commit) begin
            last_order <= wb.order;
        end
    end

    // register write port
    assign we    = commit && wb.ld_reg && !wb.store && (wb.rd != 5'd0);
    assign waddr = wb.rd;
    assign wdata = result;

    // retirement record, idle values between commits
    always_comb begin
        if (commit) begin
            commit_valid = 1'b1;
            commit_order = wb.order;
            commit_rd    = wb.rd;
            commit_wdata = result;
            commit_pc    = wb.pc;
        end else begin
            commit_valid = 1'b0;
            commit_order = '0;
            commit_rd    = '0;
            commit_wdata = '0;
            commit_pc    = rv_wb_pkg::reset_pc;
        end
    end

endmodule : wb_stage

`default_nettype wire

// ==== logic/reg_file.sv ====
/*
 * 32 x 32 integer register file.
 * One write port taking effect at the clock edge and two combinational
 * read ports without write bypass. x0 reads zero and ignores writes.
 */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 we,
    input  wire rv_wb_pkg::rv_reg_idx waddr,
    input  wire rv_wb_pkg::rv_word    wdata,
    input  wire rv_wb_pkg::rv_reg_idx raddr_a,
    input  wire rv_wb_pkg::rv_reg_idx raddr_b,
    output      rv_wb_pkg::rv_word    rdata_a,
    output      rv_wb_pkg::rv_word    rdata_b
);

    rv_wb_pkg::rv_word regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // forwarding is done upstream in decode
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule : reg_file

`default_nettype wire

// ==== logic/wb_top.sv ====
/*
 * Top of the writeback end.
 * The memory stage drives the in_* ports and result words, the commit
 * ports report one record per retired instruction, and the two read
 * ports give direct access to the register file.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire rv_wb_pkg::rv_order   in_order,
    input  wire rv_wb_pkg::rv_word    in_pc,
    input  wire rv_wb_pkg::wb_sel_e   in_sel,
    input  wire rv_wb_pkg::rv_reg_idx in_rd,
    input  wire logic                 in_ld_reg,
    input  wire logic                 in_store,
    input  wire rv_wb_pkg::rv_word    alu_out,
    input  wire logic                 br_en,
    input  wire rv_wb_pkg::rv_word    u_imm,
    input  wire rv_wb_pkg::rv_word    mem_rdata,
    input  wire logic [1:0]           mem_byte_off,
    input  wire rv_wb_pkg::rv_reg_idx raddr_a,
    input  wire rv_wb_pkg::rv_reg_idx raddr_b,
    output      rv_wb_pkg::rv_word    rdata_a,
    output      rv_wb_pkg::rv_word    rdata_b,
    output      logic                 commit_valid,
    output      rv_wb_pkg::rv_order   commit_order,
    output      rv_wb_pkg::rv_reg_idx commit_rd,
    output      rv_wb_pkg::rv_word    commit_wdata,
    output      rv_wb_pkg::rv_word    commit_pc
);

    logic                 we;
    rv_wb_pkg::rv_reg_idx waddr;
    rv_wb_pkg::rv_word    wdata;

    wb_if wb_bus ();  // registered instruction

    mem_wb_reg mem_wb_reg_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_order     (in_order),
        .in_pc        (in_pc),
        .in_sel       (in_sel),
        .in_rd        (in_rd),
        .in_ld_reg    (in_ld_reg),
        .in_store     (in_store),
        .alu_out      (alu_out),
        .br_en        (br_en),
        .u_imm        (u_imm),
        .mem_rdata    (mem_rdata),
        .mem_byte_off (mem_byte_off),
        .wb           (wb_bus.producer)
    );

    wb_stage wb_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb           (wb_bus.consumer),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata),
        .commit_pc    (commit_pc)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

endmodule : wb_top

`default_nettype wire

// ==== test/tb_wb_top.sv ====
/*
 * Testbench for the writeback end.
 * Replays the instructions in test/wb_patterns.txt, then a run of
 * pseudo-random back-to-back instructions, and checks every commit
 * record and both register read ports against a register model.
 * Inputs change on the falling edge, outputs are checked there too.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_top;

    localparam int num_patterns  = 28;
    localparam int pat_cols      = 14;
    localparam int num_random    = 24;
    localparam int reset_cycles  = 5;
    // reset, both read sweeps, all instructions and a margin
    localparam int timeout_cycles = reset_cycles + 32 + num_patterns + num_random + 34 + 50;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    rv_wb_pkg::rv_order   in_order;
    rv_wb_pkg::rv_word    in_pc;
    rv_wb_pkg::wb_sel_e   in_sel;
    rv_wb_pkg::rv_reg_idx in_rd;
    logic                 in_ld_reg;
    logic                 in_store;
    rv_wb_pkg::rv_word    alu_out;
    logic                 br_en;
    rv_wb_pkg::rv_word    u_imm;
    rv_wb_pkg::rv_word    mem_rdata;
    logic [1:0]           mem_byte_off;
    rv_wb_pkg::rv_reg_idx raddr_a;
    rv_wb_pkg::rv_reg_idx raddr_b;
    rv_wb_pkg::rv_word    rdata_a;
    rv_wb_pkg::rv_word    rdata_b;
    logic                 commit_valid;
    rv_wb_pkg::rv_order   commit_order;
    rv_wb_pkg::rv_reg_idx commit_rd;
    rv_wb_pkg::rv_word    commit_wdata;
    rv_wb_pkg::rv_word    commit_pc;

    logic [63:0]          pat_mem [num_patterns * pat_cols];
    rv_wb_pkg::rv_word    model_regs [32];  // expected register contents
    rv_wb_pkg::rv_word    rand_state;
    int                   cycle_count;

    // what the instruction driven last cycle should report now
    logic                 exp_commit;
    logic                 exp_write;
    rv_wb_pkg::rv_order   exp_order;
    rv_wb_pkg::rv_reg_idx exp_rd;
    rv_wb_pkg::rv_word    exp_wdata;
    rv_wb_pkg::rv_word    exp_pc;

    wb_top wb_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the test did not finish within %0d cycles", timeout_cycles);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input string name, input rv_wb_pkg::rv_word expected,
                              input rv_wb_pkg::rv_word actual);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run("data value mismatch");
        end
    endtask

    task automatic check_order(input string name, input rv_wb_pkg::rv_order expected,
                               input rv_wb_pkg::rv_order actual);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run("order number mismatch");
        end
    endtask

    function automatic rv_wb_pkg::rv_word lcg_next(input rv_wb_pkg::rv_word s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // writeback value by the selection rules, using shifts for sub-words
    function automatic rv_wb_pkg::rv_word select_value(input rv_wb_pkg::wb_sel_e sel,
            input rv_wb_pkg::rv_word pc, input rv_wb_pkg::rv_word alu, input logic br,
            input rv_wb_pkg::rv_word uimm, input rv_wb_pkg::rv_word rdata,
            input logic [1:0] off, input logic store);
        logic [7:0]        b;
        logic [15:0]       h;
        rv_wb_pkg::rv_word v;
        b = 8'(rdata >> {off, 3'b000});
        h = 16'(rdata >> {off[1], 4'b0000});  // aligned halfword
        case (sel)
            rv_wb_pkg::alu_out:  v = alu;
            rv_wb_pkg::br_en:    v = {31'b0, br};
            rv_wb_pkg::u_imm:    v = uimm;
            rv_wb_pkg::lw:       v = rdata;
            rv_wb_pkg::pc_plus4: v = pc + 32'd4;
            rv_wb_pkg::lb:       v = {{24{b[7]}}, b};
            rv_wb_pkg::lbu:      v = {24'b0, b};
            rv_wb_pkg::lh:       v = {{16{h[15]}}, h};
            rv_wb_pkg::lhu:      v = {16'b0, h};
            default:             v = '0;
        endcase
        return store ? '0 : v;
    endfunction

    // read ports against the model, then the commit record
    task automatic check_cycle();
        check_word("rdata_a", model_regs[raddr_a], rdata_a);
        check_word("rdata_b", model_regs[raddr_b], rdata_b);
        check_word("commit_valid", {31'b0, exp_commit}, {31'b0, commit_valid});
        if (exp_commit) begin
            check_order("commit_order", exp_order, commit_order);
            check_word("commit_rd", {27'b0, exp_rd}, {27'b0, commit_rd});
            check_word("commit_pc", exp_pc, commit_pc);
        end else begin
            check_order("commit_order", '0, commit_order);
            check_word("commit_rd", 32'd0, {27'b0, commit_rd});
            check_word("commit_pc", rv_wb_pkg::reset_pc, commit_pc);
        end
        check_word("commit_wdata", exp_wdata, commit_wdata);
        if (exp_write) begin
            model_regs[exp_rd] = exp_wdata;  // lands at the coming edge
        end
    endtask

    task automatic drive_instr(input logic valid, input rv_wb_pkg::rv_order order,
            input rv_wb_pkg::rv_word pc, input rv_wb_pkg::wb_sel_e sel,
            input rv_wb_pkg::rv_reg_idx rd, input logic ld_reg, input logic store,
            input rv_wb_pkg::rv_word alu, input logic br, input rv_wb_pkg::rv_word uimm,
            input rv_wb_pkg::rv_word rdata, input logic [1:0] off, input logic commit,
            input rv_wb_pkg::rv_word wdata);
        in_valid     = valid;
        in_order     = order;
        in_pc        = pc;
        in_sel       = sel;
        in_rd        = rd;
        in_ld_reg    = ld_reg;
        in_store     = store;
        alu_out      = alu;
        br_en        = br;
        u_imm        = uimm;
        mem_rdata    = rdata;
        mem_byte_off = off;
        exp_commit   = commit;
        exp_write    = commit && ld_reg && !store && (rd != 5'd0);
        exp_order    = order;
        exp_rd       = rd;
        exp_wdata    = commit ? wdata : '0;
        exp_pc       = pc;
    endtask

    task automatic drive_idle();
        drive_instr(1'b0, '0, '0, rv_wb_pkg::alu_out, '0, 1'b0, 1'b0, '0, 1'b0, '0, '0,
                    2'b00, 1'b0, '0);
    endtask

    task automatic drive_pattern(input int idx);
        int b;
        b = idx * pat_cols;
        drive_instr(pat_mem[b][0], pat_mem[b + 1], pat_mem[b + 2][31:0],
                    rv_wb_pkg::wb_sel_e'(pat_mem[b + 3][3:0]), pat_mem[b + 4][4:0],
                    pat_mem[b + 5][0], pat_mem[b + 6][0], pat_mem[b + 7][31:0],
                    pat_mem[b + 8][0], pat_mem[b + 9][31:0], pat_mem[b + 10][31:0],
                    pat_mem[b + 11][1:0], pat_mem[b + 12][0], pat_mem[b + 13][31:0]);
    endtask

    task automatic drive_random(input int idx);
        rv_wb_pkg::wb_sel_e   sel;
        rv_wb_pkg::rv_reg_idx rd;
        rv_wb_pkg::rv_word    ctl;
        rv_wb_pkg::rv_word    alu;
        rv_wb_pkg::rv_word    uimm;
        rv_wb_pkg::rv_word    rdata;
        rv_wb_pkg::rv_word    pc;
        logic                 store;
        rand_state = lcg_next(rand_state);
        sel        = rv_wb_pkg::wb_sel_e'(4'(rand_state % 32'd9));
        rand_state = lcg_next(rand_state);
        ctl        = rand_state;
        rd         = ctl[4:0];
        store      = (ctl[15:13] == 3'b000);  // about one in eight
        rand_state = lcg_next(rand_state);
        alu        = rand_state;
        rand_state = lcg_next(rand_state);
        uimm       = {rand_state[31:12], 12'b0};
        rand_state = lcg_next(rand_state);
        rdata      = rand_state;
        pc         = 32'h4000_1000 + 32'(idx) * 32'd4;
        drive_instr(1'b1, 64'h0000_0001_0000_0000 + 64'(idx), pc, sel, rd, 1'b1, store,
                    alu, ctl[12], uimm, rdata, ctl[9:8], 1'b1,
                    select_value(sel, pc, alu, ctl[12], uimm, rdata, ctl[9:8], store));
    endtask

    initial begin
        rst_n      = 1'b0;
        raddr_a    = '0;
        raddr_b    = '0;
        rand_state = 32'd78;
        drive_idle();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        $readmemh("test/wb_patterns.txt", pat_mem);
        if (pat_mem[(num_patterns - 1) * pat_cols + 12] !== 64'd1) begin
            abort_run("the pattern file holds fewer instructions than expected");
        end

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 32; i++) begin  // idle outputs and cleared registers
            @(negedge clk);
            check_cycle();
            raddr_a = 5'(i);
            raddr_b = 5'(31 - i);
        end

        for (int i = 0; i < num_patterns; i++) begin
            @(negedge clk);
            check_cycle();
            raddr_a = exp_rd;           // value shows after the next edge
            raddr_b = raddr_b + 5'd1;
            drive_pattern(i);
        end

        for (int i = 0; i < num_random; i++) begin
            @(negedge clk);
            check_cycle();
            raddr_a = exp_rd;
            raddr_b = raddr_b + 5'd1;
            drive_random(i);
        end

        for (int i = 0; i <= 32; i++) begin  // drain, then sweep the final state
            @(negedge clk);
            check_cycle();
            drive_idle();
            raddr_a = 5'(i);
            raddr_b = 5'(31 - i);
        end
        @(negedge clk);
        check_cycle();

        $display("** PASS **");
        $finish;
    end

endmodule : tb_wb_top

`default_nettype wire

// ==== test/wb_patterns.txt ====
// valid order pc sel rd ld_reg store alu_out br_en u_imm mem_rdata byte_off exp_commit exp_wdata
// all columns hex, one instruction per line, applied on consecutive cycles
1 1 40000000 0 01 1 0 12345678 0 00000000 00000000 0 1 12345678
1 2 40000004 1 02 1 0 deadbeef 1 00000000 00000000 0 1 00000001
1 3 40000008 2 03 1 0 00000000 0 abcde000 00000000 0 1 abcde000
1 4 4000000c 4 04 1 0 00000000 0 00000000 00000000 0 1 40000010
1 5 40000010 3 05 1 0 00000000 0 00000000 cafef00d 0 1 cafef00d
1 6 40000014 5 06 1 0 00000000 0 00000000 8a7b0c9d 0 1 ffffff9d
1 7 40000018 5 07 1 0 00000000 0 00000000 8a7b0c9d 1 1 0000000c
1 8 4000001c 5 08 1 0 00000000 0 00000000 8a7b0c9d 2 1 0000007b
1 9 40000020 5 09 1 0 00000000 0 00000000 8a7b0c9d 3 1 ffffff8a
1 a 40000024 6 0a 1 0 00000000 0 00000000 8a7b0c9d 0 1 0000009d
1 b 40000028 6 0b 1 0 00000000 0 00000000 8a7b0c9d 1 1 0000000c
1 c 4000002c 6 0c 1 0 00000000 0 00000000 8a7b0c9d 2 1 0000007b
1 d 40000030 6 0d 1 0 00000000 0 00000000 8a7b0c9d 3 1 0000008a
1 e 40000034 7 0e 1 0 00000000 0 00000000 8a7b0c9d 0 1 00000c9d
1 f 40000038 7 0f 1 0 00000000 0 00000000 8a7b0c9d 2 1 ffff8a7b
1 10 4000003c 7 12 1 0 00000000 0 00000000 8a7b0c9d 1 1 00000c9d
1 11 40000040 8 10 1 0 00000000 0 00000000 8a7b0c9d 0 1 00000c9d
1 12 40000044 8 11 1 0 00000000 0 00000000 8a7b0c9d 2 1 00008a7b
1 13 40000048 8 13 1 0 00000000 0 00000000 8a7b0c9d 3 1 00008a7b
1 14 4000004c 0 01 0 1 11111111 0 00000000 00000000 0 1 00000000
1 15 40000050 0 02 1 1 22222222 0 00000000 00000000 0 1 00000000
1 16 40000054 0 00 1 0 55aa55aa 0 00000000 00000000 0 1 55aa55aa
1 17 40000058 0 14 1 0 0badc0de 0 00000000 00000000 0 1 0badc0de
1 17 40000058 0 14 1 0 0badc0de 0 00000000 00000000 0 0 00000000
0 0 00000000 0 00 0 0 00000000 0 00000000 00000000 0 0 00000000
1 17 40000058 0 14 1 0 0badc0de 0 00000000 00000000 0 0 00000000
0 0 00000000 0 00 0 0 00000000 0 00000000 00000000 0 0 00000000
1 18 4000005c 2 15 1 0 00000000 0 7ffff000 00000000 0 1 7ffff000

// ==== vlog.f ====
logic/rv_wb_pkg.sv
logic/wb_if.sv
logic/mem_wb_reg.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/wb_top.sv
test/tb_wb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the writeback testbench with Verilator and run it.
# Exits nonzero if the build fails, the simulation fails, or the
# pass line is missing from the simulation output.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
    --top-module tb_wb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_wb_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF '** PASS **'; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi
